// ==== verilog/ice_pkg.sv ====
package ice_pkg;

	// Widest GPIO port carried by the structs
	localparam int GPIO_MAX = 8;

	// Complete host message as collected by the parser
	typedef struct packed {
		logic [7:0] msg_type;
		logic [7:0] evt_id;
		logic [7:0] length;
		logic [7:0] data0;
		logic [7:0] data1;
	} host_msg_t;

	// Slave response frame, sent out in field order
	typedef struct packed {
		logic [7:0] resp_type;
		logic [7:0] evt_id;
		// Number of data bytes that follow, 0 to 2
		logic [7:0] length;
		logic [7:0] data0;
		logic [7:0] data1;
	} resp_frame_t;

	// GPIO settings, one bit per pin
	typedef struct packed {
		logic [GPIO_MAX-1:0] direction;
		logic [GPIO_MAX-1:0] level;
		logic [GPIO_MAX-1:0] int_enable;
	} gpio_cfg_t;

	// Host command and response codes
	localparam logic [7:0] CMD_VERSION = 8'h56;
	localparam logic [7:0] CMD_SET     = 8'h6f;
	localparam logic [7:0] CMD_GET     = 8'h4f;
	localparam logic [7:0] RESP_ACK    = 8'h00;
	localparam logic [7:0] RESP_NAK    = 8'h01;
	// Asynchronous GPIO change event
	localparam logic [7:0] EVT_GPIO    = 8'h67;

	// Setting indices for get and set
	localparam logic [7:0] SET_DIR   = 8'd0;
	localparam logic [7:0] SET_LEVEL = 8'd1;
	localparam logic [7:0] SET_INTEN = 8'd2;

	// Reported by the version query
	localparam logic [7:0] VERSION_MAJOR = 8'h03;
	localparam logic [7:0] VERSION_MINOR = 8'h02;

endpackage

// ==== verilog/ice_frame_parser.sv ====
`timescale 1ns/1ps

module ice_frame_parser import ice_pkg::*; (
	input  logic       reset,
	input  logic       clk,
	input  logic [7:0] rx_char,
	input  logic       rx_char_valid,
	output host_msg_t  msg,
	output logic       msg_valid
);

	// Position in frame: 0 type, 1 event id, 2 length, 3 data
	logic [1:0] byte_pos;
	// Data bytes still to come
	logic [7:0] remaining;
	// Data slot for next byte, sticks at 2 once both are full
	logic [1:0] data_idx;

	// Frame position and completion strobe
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			byte_pos  <= 2'd0;
			remaining <= 8'd0;
			data_idx  <= 2'd0;
			msg_valid <= 1'b0;
		end else begin
			msg_valid <= 1'b0;
			if (rx_char_valid) begin
				case (byte_pos)
					2'd0: byte_pos <= 2'd1;
					2'd1: byte_pos <= 2'd2;
					2'd2: begin
						data_idx  <= 2'd0;
						remaining <= rx_char;
						// Empty frame is done at its length byte
						if (rx_char == 8'd0) begin
							msg_valid <= 1'b1;
							byte_pos  <= 2'd0;
						end else begin
							byte_pos <= 2'd3;
						end
					end
					default: begin
						remaining <= remaining - 8'd1;
						if (data_idx != 2'd2)
							data_idx <= data_idx + 2'd1;
						if (remaining == 8'd1) begin
							msg_valid <= 1'b1;
							byte_pos  <= 2'd0;
						end
					end
				endcase
			end
		end
	end

	// Field capture into the message register
	always_ff @(posedge reset) begin
		if (rx_char_valid) begin
			case (byte_pos)
				2'd0: msg.msg_type <= rx_char;
				2'd1: msg.evt_id <= rx_char;
				2'd2: begin
					msg.length <= rx_char;
					// Absent data bytes read as zero
					msg.data0  <= 8'd0;
					msg.data1  <= 8'd0;
				end
				default: begin
					if (data_idx == 2'd0)
						msg.data0 <= rx_char;
					else if (data_idx == 2'd1)
						msg.data1 <= rx_char;
					// Surplus bytes fall through here
				end
			endcase
		end
	end

endmodule

// ==== verilog/ice_settings_slave.sv ====
`timescale 1ns/1ps

module ice_settings_slave import ice_pkg::*; #(
	parameter int GPIO_WIDTH = 8
) (
	input  logic        reset,
	input  logic        clk,
	input  host_msg_t   msg,
	input  logic        msg_valid,
	output gpio_cfg_t   gpio_cfg,
	output resp_frame_t resp,
	output logic        req,
	input  logic        grant
);

	// Pins beyond GPIO_WIDTH always read zero
	localparam logic [GPIO_MAX-1:0] PIN_MASK = {GPIO_MAX{1'b1}} >> (GPIO_MAX - GPIO_WIDTH);

	logic                pending;
	logic                accept;
	logic                index_ok;
	logic                set_ok;
	logic                get_ok;
	logic [7:0]          ovf_cnt;
	logic [GPIO_MAX-1:0] setting_val;
	resp_frame_t         resp_next;

	// Still owed to the arbiter, unless granted this cycle
	assign pending  = req & ~grant;
	assign accept   = msg_valid & ~pending;
	assign index_ok = (msg.data0 <= SET_INTEN);
	assign set_ok   = (msg.msg_type == CMD_SET) && (msg.length == 8'd2) && index_ok;
	assign get_ok   = (msg.msg_type == CMD_GET) && (msg.length == 8'd1) && index_ok;

	// Setting selected by data0
	always_comb begin
		case (msg.data0)
			SET_DIR:   setting_val = gpio_cfg.direction;
			SET_LEVEL: setting_val = gpio_cfg.level;
			default:   setting_val = gpio_cfg.int_enable;
		endcase
	end

	// Reply decode, NAK unless proven otherwise
	always_comb begin
		resp_next.resp_type = RESP_NAK;
		resp_next.evt_id    = msg.evt_id;
		resp_next.length    = 8'd1;
		resp_next.data0     = ovf_cnt;
		resp_next.data1     = 8'd0;
		if (msg.msg_type == CMD_VERSION) begin
			resp_next.resp_type = CMD_VERSION;
			resp_next.length    = 8'd2;
			resp_next.data0     = VERSION_MAJOR;
			resp_next.data1     = VERSION_MINOR;
		end else if (set_ok) begin
			resp_next.resp_type = RESP_ACK;
			resp_next.length    = 8'd0;
			resp_next.data0     = 8'd0;
		end else if (get_ok) begin
			resp_next.resp_type = RESP_ACK;
			resp_next.data0     = setting_val;
		end
	end

	// Request level, overflow count and settings
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			req      <= 1'b0;
			ovf_cnt  <= 8'd0;
			gpio_cfg <= '0;
		end else begin
			if (grant)
				req <= 1'b0;
			if (msg_valid && pending) begin
				// Dropped message, count saturates
				if (ovf_cnt != 8'hff)
					ovf_cnt <= ovf_cnt + 8'd1;
			end else if (accept) begin
				req <= 1'b1;
				// NAK reports the count, then clears it
				if (resp_next.resp_type == RESP_NAK)
					ovf_cnt <= 8'd0;
				if (set_ok) begin
					case (msg.data0)
						SET_DIR:   gpio_cfg.direction <= msg.data1 & PIN_MASK;
						SET_LEVEL: gpio_cfg.level <= msg.data1 & PIN_MASK;
						default:   gpio_cfg.int_enable <= msg.data1 & PIN_MASK;
					endcase
				end
			end
		end
	end

	// Held reply frame
	always_ff @(posedge reset) begin
		if (accept)
			resp <= resp_next;
	end

endmodule

// ==== verilog/ice_gpio_slave.sv ====
`timescale 1ns/1ps

module ice_gpio_slave import ice_pkg::*; #(
	parameter int GPIO_WIDTH = 8
) (
	input  logic                  reset,
	input  logic                  clk,
	input  logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe,
	input  gpio_cfg_t             gpio_cfg,
	output resp_frame_t           resp,
	output logic                  req,
	input  logic                  grant
);

	logic [GPIO_WIDTH-1:0] sync_meta;
	logic [GPIO_WIDTH-1:0] sync_in;
	// Input value as of the last report
	logic [GPIO_WIDTH-1:0] last_rep;
	// Input pins with interrupts enabled
	logic [GPIO_WIDTH-1:0] watch;
	logic [GPIO_WIDTH-1:0] changed;
	logic [7:0]            evt_cnt;
	logic                  raise;

	assign watch   = ~gpio_cfg.direction[GPIO_WIDTH-1:0] & gpio_cfg.int_enable[GPIO_WIDTH-1:0];
	assign changed = (sync_in ^ last_rep) & watch;
	// One event in flight at a time
	assign raise   = ~req & (|changed);

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			sync_meta <= '0;
			sync_in   <= '0;
			last_rep  <= '0;
			gpio_out  <= '0;
			gpio_oe   <= '0;
			req       <= 1'b0;
			evt_cnt   <= 8'd0;
		end else begin
			// Two-flop synchronizer
			sync_meta <= gpio_in;
			sync_in   <= sync_meta;
			gpio_oe   <= gpio_cfg.direction[GPIO_WIDTH-1:0];
			gpio_out  <= gpio_cfg.level[GPIO_WIDTH-1:0];
			if (grant) begin
				req     <= 1'b0;
				evt_cnt <= evt_cnt + 8'd1;
			end
			// Frozen while pending so later changes merge
			if (!req)
				last_rep <= sync_in;
			if (raise)
				req <= 1'b1;
		end
	end

	// Event frame tagged with the event count
	always_ff @(posedge reset) begin
		if (raise) begin
			resp.resp_type <= EVT_GPIO;
			resp.evt_id    <= evt_cnt;
			resp.length    <= 8'd1;
			resp.data0     <= GPIO_MAX'(sync_in & watch);
			resp.data1     <= 8'd0;
		end
	end

endmodule

// ==== verilog/ice_response_arbiter.sv ====
`timescale 1ns/1ps

module ice_response_arbiter import ice_pkg::*; (
	input  logic        reset,
	input  logic        clk,
	input  resp_frame_t resp_settings,
	input  logic        req_settings,
	input  resp_frame_t resp_gpio,
	input  logic        req_gpio,
	output logic        grant_settings,
	output logic        grant_gpio,
	output logic [7:0]  tx_char,
	output logic        tx_char_valid,
	input  logic        tx_char_ready
);

	localparam int FRAME_BITS = $bits(resp_frame_t);

	logic                  busy;
	// Frame owner, 1 for the GPIO slave
	logic                  owner_gpio;
	logic [2:0]            byte_idx;
	logic [2:0]            last_idx;
	logic [2:0]            win_last;
	logic                  start;
	logic                  last_byte;
	resp_frame_t           winner;
	logic [FRAME_BITS-1:0] shift_q;

	// Settings slave wins ties
	assign winner   = req_settings ? resp_settings : resp_gpio;
	// Header is 3 bytes, data clamped to 2
	assign win_last = (winner.length >= 8'd2) ? 3'd4 : 3'd2 + winner.length[2:0];

	// Wait out the grant cycle, the old request is still up
	assign start = ~busy & ~grant_settings & ~grant_gpio & (req_settings | req_gpio);

	// Head of the shift register goes out when the host is ready
	assign tx_char       = shift_q[FRAME_BITS-1 -: 8];
	assign tx_char_valid = busy & tx_char_ready;
	assign last_byte     = tx_char_valid & (byte_idx == last_idx);

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			busy           <= 1'b0;
			owner_gpio     <= 1'b0;
			byte_idx       <= 3'd0;
			last_idx       <= 3'd0;
			grant_settings <= 1'b0;
			grant_gpio     <= 1'b0;
		end else begin
			grant_settings <= 1'b0;
			grant_gpio     <= 1'b0;
			if (start) begin
				busy       <= 1'b1;
				owner_gpio <= ~req_settings;
				byte_idx   <= 3'd0;
				last_idx   <= win_last;
			end else if (tx_char_valid) begin
				byte_idx <= byte_idx + 3'd1;
				// Grant pulse closes the frame
				if (last_byte) begin
					busy           <= 1'b0;
					grant_settings <= ~owner_gpio;
					grant_gpio     <= owner_gpio;
				end
			end
		end
	end

	// Frame shifts up one byte per accepted byte
	always_ff @(posedge reset) begin
		if (start)
			shift_q <= winner;
		else if (tx_char_valid)
			shift_q <= {shift_q[FRAME_BITS-9:0], 8'h00};
	end

endmodule

// ==== verilog/ice_bus_top.sv ====
`timescale 1ns/1ps

module ice_bus_top import ice_pkg::*; #(
	parameter int GPIO_WIDTH = 8
) (
	input  logic                  reset,
	input  logic                  clk,
	input  logic [7:0]            rx_char,
	input  logic                  rx_char_valid,
	output logic [7:0]            tx_char,
	output logic                  tx_char_valid,
	input  logic                  tx_char_ready,
	input  logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe
);

	host_msg_t   msg;
	logic        msg_valid;
	gpio_cfg_t   gpio_cfg;
	resp_frame_t resp_settings;
	resp_frame_t resp_gpio;
	logic        req_settings;
	logic        req_gpio;
	logic        grant_settings;
	logic        grant_gpio;

	// Host bytes into whole messages
	ice_frame_parser u_parser (
		.reset(reset), .clk(clk),
		.rx_char(rx_char), .rx_char_valid(rx_char_valid),
		.msg(msg), .msg_valid(msg_valid)
	);

	// Commands and the GPIO settings
	ice_settings_slave #(.GPIO_WIDTH(GPIO_WIDTH)) u_settings (
		.reset(reset), .clk(clk),
		.msg(msg), .msg_valid(msg_valid), .gpio_cfg(gpio_cfg),
		.resp(resp_settings), .req(req_settings), .grant(grant_settings)
	);

	// Pins and change events
	ice_gpio_slave #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
		.reset(reset), .clk(clk),
		.gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe), .gpio_cfg(gpio_cfg),
		.resp(resp_gpio), .req(req_gpio), .grant(grant_gpio)
	);

	// One reply frame at a time back to the host
	ice_response_arbiter u_arbiter (
		.reset(reset), .clk(clk),
		.resp_settings(resp_settings), .req_settings(req_settings),
		.resp_gpio(resp_gpio), .req_gpio(req_gpio),
		.grant_settings(grant_settings), .grant_gpio(grant_gpio),
		.tx_char(tx_char), .tx_char_valid(tx_char_valid), .tx_char_ready(tx_char_ready)
	);

endmodule

// ==== verification/tb_ice_bus.sv ====
`timescale 1ns/1ps

module tb_ice_bus;

	localparam int GPIO_WIDTH = 6;
	localparam int MAX_TESTS  = 32;
	// Quiet cycles with no stray frame after a test
	localparam int QUIET      = 24;

	// Clock is named reset and reset is named clk
	logic                  reset = 1'b0;
	logic                  clk;
	logic [7:0]            rx_char;
	logic                  rx_char_valid;
	logic [7:0]            tx_char;
	logic                  tx_char_valid;
	logic                  tx_char_ready = 1'b0;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic [GPIO_WIDTH-1:0] gpio_oe;

	// Test table as read from the data file
	logic [127:0] names [MAX_TESTS];
	int           host_n [MAX_TESTS];
	logic [7:0]   host_b [MAX_TESTS][8];
	logic [7:0]   gin [MAX_TESTS];
	int           exp_n [MAX_TESTS];
	logic [7:0]   exp_b [MAX_TESTS][5];
	logic [7:0]   exp_out [MAX_TESTS];
	logic [7:0]   exp_oe [MAX_TESTS];
	int           n_tests;
	logic         bad_file;

	// Bytes seen on the transmit side in arrival order
	logic [7:0]   rx_q [$];
	logic [31:0]  rand_state = 32'd99594;
	int           cycles = 0;
	int           limit;
	int           errors;
	int           failed_tests;

	ice_bus_top #(.GPIO_WIDTH(GPIO_WIDTH)) uut (
		.reset(reset), .clk(clk),
		.rx_char(rx_char), .rx_char_valid(rx_char_valid),
		.tx_char(tx_char), .tx_char_valid(tx_char_valid), .tx_char_ready(tx_char_ready),
		.gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe)
	);

	// 40 ns clock
	initial begin
		forever #20 reset = ~reset;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Host stalls roughly one cycle in four
	always @(negedge reset) begin
		rand_state    = next_rand(rand_state);
		tx_char_ready = (rand_state[1:0] != 2'b00);
	end

	// Collect every accepted byte
	always @(posedge reset) begin
		if (tx_char_valid)
			rx_q.push_back(tx_char);
	end

	// Hard stop at the cycle limit
	always @(posedge reset) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout: run still busy after %0d cycles", limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic read_hex(input int fd, output logic [7:0] v);
		int r;
		r = $fscanf(fd, "%h", v);
		if (r != 1)
			bad_file = 1'b1;
	endtask

	task automatic load_tests(input int fd);
		logic [127:0]  tok;
		logic [2047:0] skip;
		logic [7:0]    v;
		int            r;
		int            i;
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			// Rest of a comment line is dropped
			if (tok[7:0] == "#") begin
				r = $fgets(skip, fd);
				continue;
			end
			names[n_tests] = tok;
			read_hex(fd, v);
			host_n[n_tests] = {24'd0, v};
			for (i = 0; i < 8; i++) begin
				read_hex(fd, v);
				host_b[n_tests][i] = v;
			end
			read_hex(fd, v);
			gin[n_tests] = v;
			read_hex(fd, v);
			exp_n[n_tests] = {24'd0, v};
			for (i = 0; i < 5; i++) begin
				read_hex(fd, v);
				exp_b[n_tests][i] = v;
			end
			read_hex(fd, v);
			exp_out[n_tests] = v;
			read_hex(fd, v);
			exp_oe[n_tests] = v;
			if (host_n[n_tests] > 8 || exp_n[n_tests] > 5)
				bad_file = 1'b1;
			n_tests++;
		end
	endtask

	task automatic run_test(input int t);
		int         i;
		int         errs_before;
		logic [7:0] got;
		errs_before = errors;
		@(negedge reset);
		gpio_in = gin[t][GPIO_WIDTH-1:0];
		// One host byte per cycle
		for (i = 0; i < host_n[t]; i++) begin
			rx_char       = host_b[t][i];
			rx_char_valid = 1'b1;
			@(negedge reset);
		end
		rx_char_valid = 1'b0;
		while (rx_q.size() < exp_n[t])
			@(negedge reset);
		for (i = 0; i < exp_n[t]; i++) begin
			got = rx_q.pop_front();
			assert (got == exp_b[t][i]) else begin
				$display("Mismatch in %0s, byte %0d: expected %02h, actual %02h",
					names[t], i, exp_b[t][i], got);
				errors++;
			end
		end
		// Nothing more may follow
		repeat (QUIET) @(negedge reset);
		assert (rx_q.size() == 0) else begin
			$display("Test %0s sent %0d bytes more than expected", names[t], rx_q.size());
			rx_q.delete();
			errors++;
		end
		assert (gpio_out == exp_out[t][GPIO_WIDTH-1:0]) else begin
			$display("Mismatch in %0s, gpio_out: expected %02h, actual %02h",
				names[t], exp_out[t][GPIO_WIDTH-1:0], gpio_out);
			errors++;
		end
		assert (gpio_oe == exp_oe[t][GPIO_WIDTH-1:0]) else begin
			$display("Mismatch in %0s, gpio_oe: expected %02h, actual %02h",
				names[t], exp_oe[t][GPIO_WIDTH-1:0], gpio_oe);
			errors++;
		end
		if (errors == errs_before) begin
			$display("Test %0s: ok", names[t]);
		end else begin
			$display("Test %0s: error", names[t]);
			failed_tests++;
		end
	endtask

	initial begin
		int fd;
		int t;
		clk           = 1'b1;
		rx_char       = 8'h00;
		rx_char_valid = 1'b0;
		gpio_in       = '0;
		limit         = 0;
		errors        = 0;
		failed_tests  = 0;
		n_tests       = 0;
		bad_file      = 1'b0;
		fd = $fopen("verification/ice_testdata.txt", "r");
		if (fd == 0) begin
			bad_file = 1'b1;
		end else begin
			load_tests(fd);
			$fclose(fd);
		end
		assert (!bad_file && n_tests > 0) else begin
			$display("Test data file missing or malformed");
			errors++;
		end
		limit = 300 * n_tests;
		repeat (3) @(negedge reset);
		clk = 1'b0;
		// Idle outputs once out of reset
		assert (!tx_char_valid && gpio_out == '0 && gpio_oe == '0) else begin
			$display("Outputs not idle after reset");
			errors++;
		end
		for (t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
			n_tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== verification/ice_testdata.txt ====
# name nh host0-host7 gpio_in ne exp0-exp4 gpio_out gpio_oe
# All values hex, unused byte slots hold 00, GPIO port is 6 bits wide
version       3 56 11 00 00 00 00 00 00  00  5 56 11 02 03 02  00 00
set_dir       5 6f 21 02 00 f0 00 00 00  00  3 00 21 00 00 00  00 30
set_level     5 6f 22 02 01 ff 00 00 00  00  3 00 22 00 00 00  3f 30
get_dir       4 4f 23 01 00 00 00 00 00  00  4 00 23 01 30 00  3f 30
get_level     4 4f 24 01 01 00 00 00 00  00  4 00 24 01 3f 00  3f 30
set_surplus   7 6f 25 04 00 0f aa bb 00  00  4 01 25 01 00 00  3f 30
get_dir_again 4 4f 26 01 00 00 00 00 00  00  4 00 26 01 30 00  3f 30
set_inten     5 6f 27 02 02 0f 00 00 00  00  3 00 27 00 00 00  3f 30
get_inten     4 4f 28 01 02 00 00 00 00  00  4 00 28 01 0f 00  3f 30
unknown_type  3 58 29 00 00 00 00 00 00  00  4 01 29 01 00 00  3f 30
bad_index     4 4f 2a 01 05 00 00 00 00  00  4 01 2a 01 00 00  3f 30
bad_length    5 4f 2b 02 00 01 00 00 00  00  4 01 2b 01 00 00  3f 30
gpio_evt_a    0 00 00 00 00 00 00 00 00  05  4 67 00 01 05 00  3f 30
gpio_evt_b    0 00 00 00 00 00 00 00 00  0d  4 67 01 01 0d 00  3f 30
gpio_not_en   0 00 00 00 00 00 00 00 00  1d  0 00 00 00 00 00  3f 30
gpio_evt_c    0 00 00 00 00 00 00 00 00  1c  4 67 02 01 0c 00  3f 30
gpio_out_pin  0 00 00 00 00 00 00 00 00  3c  0 00 00 00 00 00  3f 30
version_again 3 56 30 00 00 00 00 00 00  3c  5 56 30 02 03 02  3f 30
set_level_low 5 6f 31 02 01 05 00 00 00  3c  3 00 31 00 00 00  05 30
set_dir_wide  5 6f 32 02 00 ff 00 00 00  3c  3 00 32 00 00 00  05 3f
gpio_all_out  0 00 00 00 00 00 00 00 00  00  0 00 00 00 00 00  05 3f
get_dir_wide  4 4f 33 01 00 00 00 00 00  00  4 00 33 01 3f 00  05 3f
get_level_low 4 4f 34 01 01 00 00 00 00  00  4 00 34 01 05 00  05 3f

// ==== build.f ====
verilog/ice_pkg.sv
verilog/ice_frame_parser.sv
verilog/ice_settings_slave.sv
verilog/ice_gpio_slave.sv
verilog/ice_response_arbiter.sv
verilog/ice_bus_top.sv
verification/tb_ice_bus.sv

// ==== Makefile ====
# Verilator simulation of the host-interface bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_ice_bus -f build.f --Mdir obj_dir -o sim_ice_bus

run: compile
	./obj_dir/sim_ice_bus | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
